// File: logic/mem_pkg.sv
// Memory subsystem definitions
package mem_pkg;

    // Bus and line geometry
    localparam int BEAT_W         = 32;
    localparam int BEATS_PER_LINE = 8;
    localparam int LINE_W         = BEAT_W * BEATS_PER_LINE;
    localparam int BEAT_CNT_W     = $clog2(BEATS_PER_LINE);

    // Backing RAM
    localparam int RAM_WORD_W = 64;  // Two beats per word
    localparam int RAM_DEPTH  = 1024;
    localparam int RAM_ADDR_W = $clog2(RAM_DEPTH);

    // Byte addressing
    localparam int LINE_BYTES = 32;
    localparam int LINE_OFF_W = $clog2(LINE_BYTES);
    localparam int MEM_BYTES  = 8192;
    localparam int MEM_ADDR_W = $clog2(MEM_BYTES);

    // One bus beat or byte address
    typedef logic [BEAT_W-1:0] beat_t;

    typedef logic [RAM_WORD_W-1:0] ram_word_t;

    typedef logic [RAM_ADDR_W-1:0] ram_addr_t;

    // Beat 0 sits in the low bits
    typedef logic [LINE_W-1:0] line_t;

endpackage

// File: logic/word_ram.sv
// Single-port word RAM
`timescale 1ns/1ps

module word_ram
    import mem_pkg::*;
(
    input  logic      itf,
    input  logic      en,
    input  logic      we,
    input  ram_addr_t addr,
    input  ram_word_t wdata,
    output ram_word_t rdata
);

    ram_word_t mem [0:RAM_DEPTH-1];

    // Block RAM style, read-first is not needed since write and read never share a cycle
    always_ff @(posedge itf) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];  // Registered read
            end
        end
    end

endmodule

// File: logic/burst_mem_ctrl.sv
// Burst memory controller
`timescale 1ns/1ps

module burst_mem_ctrl
    import mem_pkg::*;
(
    input  logic      itf,
    input  logic      rst,
    input  logic      read_en,
    input  logic      write_en,
    input  logic      address_on,
    input  logic      data_on,
    input  beat_t     bus_c_to_m,
    input  ram_word_t ram_rdata,
    output logic      resp,
    output logic      bus_err,
    output beat_t     bus_m_to_c,
    output logic      ram_en,
    output logic      ram_we,
    output ram_addr_t ram_addr,
    output ram_word_t ram_wdata
);

    typedef enum logic [2:0] {
        s_idle,
        s_addr,
        s_wr_beats,
        s_rd_fetch,
        s_rd_beats,
        s_respond
    } state_t;

    state_t state;
    state_t next_state;

    logic [BEAT_CNT_W-1:0] beat;
    logic [BEAT_CNT_W-2:0] word_sel;    // RAM word within the line
    logic [MEM_ADDR_W-1:LINE_OFF_W] line_idx;
    logic out_of_range;
    logic store_addr;
    logic beat_ack;
    logic wr_word;
    beat_t low_half;

    assign wr_word = beat[0] && !out_of_range;  // Odd beat completes a word

    always_comb begin
        next_state = state;
        resp = 1'b0;
        store_addr = 1'b0;
        beat_ack = 1'b0;
        ram_en = 1'b0;
        ram_we = 1'b0;
        word_sel = beat[BEAT_CNT_W-1:1];
        case (state)
            s_idle: begin
                if (read_en || write_en) begin
                    next_state = s_addr;
                end
            end
            s_addr: begin
                if (address_on) begin
                    resp = 1'b1;
                    store_addr = 1'b1;
                    next_state = write_en ? s_wr_beats : s_rd_fetch;
                end
            end
            s_wr_beats: begin
                if (data_on) begin
                    resp = 1'b1;
                    beat_ack = 1'b1;
                    ram_en = wr_word;
                    ram_we = wr_word;
                    if (&beat) begin
                        next_state = s_respond;
                    end
                end
            end
            s_rd_fetch: begin
                ram_en = 1'b1;  // First word of the line
                next_state = s_rd_beats;
            end
            s_rd_beats: begin
                resp = 1'b1;
                beat_ack = 1'b1;
                // Fetch the next word while the high half goes out
                word_sel = beat[BEAT_CNT_W-1:1] + 1'b1;
                ram_en = beat[0] && !(&beat);
                if (&beat) begin
                    next_state = s_respond;
                end
            end
            s_respond: begin
                resp = 1'b1;
                next_state = s_idle;
            end
            default: begin
                next_state = s_idle;
            end
        endcase
    end

    always_ff @(posedge itf) begin
        if (rst) begin
            state <= s_idle;
            beat <= '0;
            out_of_range <= 1'b0;
        end else begin
            state <= next_state;
            if (store_addr) begin
                beat <= '0;
                out_of_range <= bus_c_to_m >= BEAT_W'(MEM_BYTES);
            end else if (beat_ack) begin
                beat <= beat + 1'b1;
            end
        end
    end

    // Address and write-data holding
    always_ff @(posedge itf) begin
        if (store_addr) begin
            line_idx <= bus_c_to_m[MEM_ADDR_W-1:LINE_OFF_W];
        end
        if (state == s_wr_beats && data_on && !beat[0]) begin
            low_half <= bus_c_to_m;
        end
    end

    assign ram_addr  = {line_idx, word_sel};
    assign ram_wdata = {bus_c_to_m, low_half};  // Even beat in low half

    assign bus_err = (state == s_respond) && out_of_range;

    always_comb begin
        bus_m_to_c = '0;
        if (state == s_rd_beats && !out_of_range) begin
            bus_m_to_c = beat[0] ? ram_rdata[RAM_WORD_W-1:BEAT_W] : ram_rdata[BEAT_W-1:0];
        end
    end

endmodule

// File: logic/line_bus_master.sv
// Line to burst bus master
`timescale 1ns/1ps

module line_bus_master
    import mem_pkg::*;
(
    input  logic  itf,
    input  logic  rst,
    input  logic  rd_req,
    input  logic  wr_req,
    input  beat_t line_addr,
    input  line_t wr_line,
    input  logic  resp,
    input  logic  bus_err,
    input  beat_t bus_m_to_c,
    output logic  busy,
    output logic  done,
    output logic  err,
    output line_t rd_line,
    output logic  read_en,
    output logic  write_en,
    output logic  address_on,
    output logic  data_on,
    output beat_t bus_c_to_m
);

    typedef enum logic [1:0] {
        m_idle,
        m_addr,
        m_xfer,
        m_done
    } state_t;

    state_t state;

    logic is_read;
    logic err_q;
    logic [BEAT_CNT_W:0] ack_cnt;  // Data acks seen, 0 to BEATS_PER_LINE
    logic all_beats;
    logic accept;
    logic in_burst;
    beat_t addr_q;
    line_t line_q;  // Write beats shift out, read beats shift in

    assign all_beats = ack_cnt[BEAT_CNT_W];
    assign accept    = (state == m_idle) && (rd_req || wr_req);
    assign in_burst  = (state == m_addr) || (state == m_xfer);

    always_ff @(posedge itf) begin
        if (rst) begin
            state <= m_idle;
            is_read <= 1'b0;
            err_q <= 1'b0;
            ack_cnt <= '0;
        end else begin
            case (state)
                m_idle: begin
                    if (accept) begin
                        is_read <= rd_req;  // Read wins a tie
                        state <= m_addr;
                    end
                end
                m_addr: begin
                    if (resp) begin
                        ack_cnt <= '0;
                        state <= m_xfer;
                    end
                end
                m_xfer: begin
                    if (resp) begin
                        if (all_beats) begin
                            err_q <= bus_err;  // Completion
                            state <= m_done;
                        end else begin
                            ack_cnt <= ack_cnt + 1'b1;
                        end
                    end
                end
                m_done: begin
                    state <= m_idle;
                end
                default: begin
                    state <= m_idle;
                end
            endcase
        end
    end

    always_ff @(posedge itf) begin
        if (accept) begin
            addr_q <= {line_addr[BEAT_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};
            line_q <= wr_line;
        end else if (state == m_xfer && resp && !all_beats) begin
            line_q <= {bus_m_to_c, line_q[LINE_W-1:BEAT_W]};
        end
    end

    assign busy    = state != m_idle;
    assign done    = state == m_done;
    assign err     = done && err_q;
    assign rd_line = line_q;

    assign read_en    = in_burst && is_read;
    assign write_en   = in_burst && !is_read;
    assign address_on = state == m_addr;
    assign data_on    = (state == m_xfer) && !is_read && !all_beats;
    assign bus_c_to_m = address_on ? addr_q : line_q[BEAT_W-1:0];

endmodule

// File: logic/mem_subsys.sv
// Line memory subsystem top
`timescale 1ns/1ps

module mem_subsys
    import mem_pkg::*;
(
    input  logic  itf,
    input  logic  rst,
    input  logic  rd_req,
    input  logic  wr_req,
    input  beat_t line_addr,
    input  line_t wr_line,
    output logic  busy,
    output logic  done,
    output logic  err,
    output line_t rd_line
);

    // Burst bus
    logic  read_en;
    logic  write_en;
    logic  address_on;
    logic  data_on;
    logic  resp;
    logic  bus_err;
    beat_t bus_c_to_m;
    beat_t bus_m_to_c;

    // RAM port
    logic      ram_en;
    logic      ram_we;
    ram_addr_t ram_addr;
    ram_word_t ram_wdata;
    ram_word_t ram_rdata;

    line_bus_master master0 (
        .itf        (itf),
        .rst        (rst),
        .rd_req     (rd_req),
        .wr_req     (wr_req),
        .line_addr  (line_addr),
        .wr_line    (wr_line),
        .resp       (resp),
        .bus_err    (bus_err),
        .bus_m_to_c (bus_m_to_c),
        .busy       (busy),
        .done       (done),
        .err        (err),
        .rd_line    (rd_line),
        .read_en    (read_en),
        .write_en   (write_en),
        .address_on (address_on),
        .data_on    (data_on),
        .bus_c_to_m (bus_c_to_m)
    );

    burst_mem_ctrl ctrl0 (
        .itf        (itf),
        .rst        (rst),
        .read_en    (read_en),
        .write_en   (write_en),
        .address_on (address_on),
        .data_on    (data_on),
        .bus_c_to_m (bus_c_to_m),
        .ram_rdata  (ram_rdata),
        .resp       (resp),
        .bus_err    (bus_err),
        .bus_m_to_c (bus_m_to_c),
        .ram_en     (ram_en),
        .ram_we     (ram_we),
        .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata)
    );

    word_ram ram0 (
        .itf   (itf),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

// File: tests/mem_subsys_chk.sv
// Burst bus and line port assertions
`timescale 1ns/1ps

module mem_subsys_chk (
    input logic itf,
    input logic rst,
    input logic read_en,
    input logic write_en,
    input logic resp,
    input logic busy,
    input logic done,
    input logic err
);

    int assert_fails = 0;

    one_direction: assert property (@(posedge itf) disable iff (rst) !(read_en && write_en))
        else begin
            assert_fails++;
            $error("read_en and write_en high together");
        end

    err_with_done: assert property (@(posedge itf) disable iff (rst) err |-> done)
        else begin
            assert_fails++;
            $error("err high without done");
        end

    done_while_busy: assert property (@(posedge itf) disable iff (rst) done |-> busy)
        else begin
            assert_fails++;
            $error("done high while not busy");
        end

    // Controller only answers an open transaction
    resp_needs_enable: assert property (@(posedge itf) disable iff (rst)
        (!read_en && !write_en) |-> !resp)
        else begin
            assert_fails++;
            $error("resp high with both enables low");
        end

endmodule

bind mem_subsys mem_subsys_chk chk0 (.*);

// File: tests/mem_subsys_tb.sv
// Memory subsystem testbench
`timescale 1ns/1ps

module mem_subsys_tb
    import mem_pkg::*;
();

    localparam int MAX_RECS     = 32;
    localparam int REC_WORDS    = 4;    // Op, address, line, err
    localparam int REC_CYCLES   = 40;
    localparam int SLACK_CYCLES = 100;
    localparam int QUIET_CYCLES = 20;

    localparam logic [3:0] OP_WRITE      = 4'h1;
    localparam logic [3:0] OP_READ       = 4'h2;
    localparam logic [3:0] OP_READ_EXTRA = 4'h3;
    localparam logic [3:0] OP_RESET_MID  = 4'h4;

    logic  itf;
    logic  rst;
    logic  rd_req;
    logic  wr_req;
    beat_t line_addr;
    line_t wr_line;
    logic  busy;
    logic  done;
    logic  err;
    line_t rd_line;

    logic [LINE_W-1:0] pat_mem [0:MAX_RECS*REC_WORDS-1];
    int     n_recs = 0;
    int     timeout_cycles = 0;
    integer seed = 24;

    mem_subsys dut0 (
        .itf       (itf),
        .rst       (rst),
        .rd_req    (rd_req),
        .wr_req    (wr_req),
        .line_addr (line_addr),
        .wr_line   (wr_line),
        .busy      (busy),
        .done      (done),
        .err       (err),
        .rd_line   (rd_line)
    );

    always #5 itf = ~itf;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_line(input line_t got, input line_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] t=%0t %s\n  got      %h\n  expected %h",
                $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] t=%0t %s: got %b expected %b", $time, what, got, exp));
        end
    endtask

    // Pulses a request for one cycle and returns on the accepting edge
    task automatic send_request(input logic rd, input logic wr, input beat_t addr,
                                input line_t line);
        @(posedge itf);
        rd_req <= rd;
        wr_req <= wr;
        line_addr <= addr;
        wr_line <= line;
        @(posedge itf);
        rd_req <= 1'b0;
        wr_req <= 1'b0;
    endtask

    task automatic wait_for_done();
        @(negedge itf);
        while (done !== 1'b1) begin
            @(negedge itf);
        end
    endtask

    task automatic run_record(input int idx);
        logic [3:0] op;
        beat_t      addr;
        line_t      line;
        logic       exp_err;
        string      tag;
        op = pat_mem[idx*REC_WORDS][3:0];
        addr = pat_mem[idx*REC_WORDS+1][BEAT_W-1:0];
        line = pat_mem[idx*REC_WORDS+2];
        exp_err = pat_mem[idx*REC_WORDS+3][0];
        tag = $sformatf("record %0d", idx);
        case (op)
            OP_WRITE: begin
                send_request(1'b0, 1'b1, addr, line);
                wait_for_done();
                check_flag(err, exp_err, {tag, " write err"});
            end
            OP_READ: begin
                send_request(1'b1, 1'b0, addr, '0);
                wait_for_done();
                check_flag(err, exp_err, {tag, " read err"});
                check_line(rd_line, line, {tag, " rd_line"});
            end
            OP_READ_EXTRA: begin
                send_request(1'b1, 1'b0, addr, '0);
                @(negedge itf);
                check_flag(busy, 1'b1, {tag, " busy during burst"});
                send_request(1'b0, 1'b1, addr, ~line);  // Must be ignored
                wait_for_done();
                check_flag(err, exp_err, {tag, " read err"});
                check_line(rd_line, line, {tag, " rd_line"});
                repeat (QUIET_CYCLES) begin
                    @(negedge itf);
                    check_flag(done, 1'b0, {tag, " extra done"});
                end
            end
            OP_RESET_MID: begin
                send_request(1'b0, 1'b1, addr, line);
                repeat (5) @(posedge itf);  // Into the write beats
                rst <= 1'b1;
                repeat (2) @(posedge itf);
                rst <= 1'b0;
                repeat (3) begin
                    @(negedge itf);
                    check_flag(busy, 1'b0, {tag, " busy after reset"});
                    check_flag(done, 1'b0, {tag, " done after reset"});
                    check_flag(err, 1'b0, {tag, " err after reset"});
                end
            end
            default: begin
                abort_run($sformatf("Record %0d has an unknown op code %h", idx, op));
            end
        endcase
        if (op != OP_RESET_MID) begin
            @(negedge itf);
            check_flag(busy, 1'b0, {tag, " busy after done"});
        end
    endtask

    initial begin
        int i;
        int gap;
        itf = 1'b0;
        rst = 1'b1;
        rd_req = 1'b0;
        wr_req = 1'b0;
        line_addr = '0;
        wr_line = '0;
        for (i = 0; i < MAX_RECS * REC_WORDS; i++) begin
            pat_mem[i] = '0;
        end
        $readmemh("tests/mem_patterns.hex", pat_mem);
        while (n_recs < MAX_RECS && pat_mem[n_recs*REC_WORDS][3:0] != 4'h0) begin
            n_recs++;
        end
        if (n_recs == 0) begin
            abort_run("No records found in tests/mem_patterns.hex");
        end
        timeout_cycles = n_recs * REC_CYCLES + SLACK_CYCLES;
        repeat (3) @(posedge itf);
        rst <= 1'b0;
        for (i = 0; i < n_recs; i++) begin
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) @(posedge itf);
            run_record(i);
        end
        repeat (5) @(posedge itf);
        if (dut0.chk0.assert_fails == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            abort_run($sformatf("Bus checker reported %0d assertion failures",
                dut0.chk0.assert_fails));
        end
    end

    // Watchdog
    initial begin
        wait (timeout_cycles != 0);
        repeat (timeout_cycles) @(posedge itf);
        abort_run($sformatf("Timeout: done never came within %0d cycles", timeout_cycles));
    end

endmodule

// File: tests/mem_patterns.hex
// Columns: op, byte address, line (beat 7 on the left, beat 0 on the right), expected err
// Ops: 1 write, 2 read, 3 read with an extra request while busy, 4 reset during a write
1 00000000 a5a50007a5a50006a5a50005a5a50004a5a50003a5a50002a5a50001a5a50000 0
2 00000000 a5a50007a5a50006a5a50005a5a50004a5a50003a5a50002a5a50001a5a50000 0
1 00001fe0 b6b60007b6b60006b6b60005b6b60004b6b60003b6b60002b6b60001b6b60000 0
1 00000420 c3c30007c3c30006c3c30005c3c30004c3c30003c3c30002c3c30001c3c30000 0
2 00001fe0 b6b60007b6b60006b6b60005b6b60004b6b60003b6b60002b6b60001b6b60000 0
1 00000434 d4d40007d4d40006d4d40005d4d40004d4d40003d4d40002d4d40001d4d40000 0
2 0000043c d4d40007d4d40006d4d40005d4d40004d4d40003d4d40002d4d40001d4d40000 0
2 00000000 a5a50007a5a50006a5a50005a5a50004a5a50003a5a50002a5a50001a5a50000 0
3 00001fe0 b6b60007b6b60006b6b60005b6b60004b6b60003b6b60002b6b60001b6b60000 0
2 00001fe0 b6b60007b6b60006b6b60005b6b60004b6b60003b6b60002b6b60001b6b60000 0
1 00002000 e1e10007e1e10006e1e10005e1e10004e1e10003e1e10002e1e10001e1e10000 1
2 00002000 0000000000000000000000000000000000000000000000000000000000000000 1
2 00000000 a5a50007a5a50006a5a50005a5a50004a5a50003a5a50002a5a50001a5a50000 0
2 00001fe0 b6b60007b6b60006b6b60005b6b60004b6b60003b6b60002b6b60001b6b60000 0
1 ffffffe0 e1e10007e1e10006e1e10005e1e10004e1e10003e1e10002e1e10001e1e10000 1
2 00001fe0 b6b60007b6b60006b6b60005b6b60004b6b60003b6b60002b6b60001b6b60000 0
2 00000420 d4d40007d4d40006d4d40005d4d40004d4d40003d4d40002d4d40001d4d40000 0
4 00000420 f0f00007f0f00006f0f00005f0f00004f0f00003f0f00002f0f00001f0f00000 0
1 00000420 9797000797970006979700059797000497970003979700029797000197970000 0
2 00000420 9797000797970006979700059797000497970003979700029797000197970000 0
2 00000000 a5a50007a5a50006a5a50005a5a50004a5a50003a5a50002a5a50001a5a50000 0
2 00001fe0 b6b60007b6b60006b6b60005b6b60004b6b60003b6b60002b6b60001b6b60000 0

// File: flist.f
logic/mem_pkg.sv
logic/word_ram.sv
logic/burst_mem_ctrl.sv
logic/line_bus_master.sv
logic/mem_subsys.sv
tests/mem_subsys_chk.sv
tests/mem_subsys_tb.sv

// File: Bender.yml
package:
  name: mem_subsys

sources:
  - logic/mem_pkg.sv
  - logic/word_ram.sv
  - logic/burst_mem_ctrl.sv
  - logic/line_bus_master.sv
  - logic/mem_subsys.sv
  - target: test
    files:
      - tests/mem_subsys_chk.sv
      - tests/mem_subsys_tb.sv
